/* tileMem.f */
rtl/tilePkg.sv
rtl/fabricIf.sv
rtl/dualPortMem.sv
rtl/transFifo.sv
rtl/fabricArbiter.sv
rtl/fabricRspPath.sv
rtl/coreReqRouter.sv
rtl/tileMemWrap.sv
testbench/tbClock.sv
testbench/tileMem_asserts.sv
testbench/tileMemTb.sv

/* testbench/tileMemTb.sv */
// Own tile id is 2A, remote tiles are 40 to 4F, region 7 is the miss region, 16 slots per memory
module tileMemTb;
    import tilePkg::*;

    localparam tileIdT OwnTile    = 8'h2A;
    localparam regionT MissRegion = 4'd7;
    localparam int     Words      = 16;             // Slots used per memory
    localparam int     NumOps     = 4 * Words + (24 + Words) + 24 + 2 * Words + 80;

    logic     Clock;
    logic     rst;
    addrT     PcQ100H;
    wordT     InstructionQ101H;
    addrT     DMemAddressQ103H;
    wordT     DMemWrDataQ103H;
    byteEnT   DMemByteEnQ103H;
    logic     DMemWrEnQ103H;
    logic     DMemRdEnQ103H;
    wordT     DMemRdRspQ104H;
    logic     CoreStall;
    logic     InFabricValid;
    logic     InFabricReady;
    addrT     InFabricAddress;
    wordT     InFabricData;
    opcodeT   InFabricOpcode;
    tileIdT   InFabricRequestorId;
    logic     OutFabricValid;
    logic     OutFabricReady;
    addrT     OutFabricAddress;
    wordT     OutFabricData;
    opcodeT   OutFabricOpcode;
    tileIdT   OutFabricRequestorId;

    // Reference model
    wordT        iModel [1024];
    wordT        dModel [2048];
    transVecT    rspQ [$];                          // Expected read responses
    transVecT    reqQ [$];                          // Expected remote core requests
    logic [31:0] rngState   = 32'd60549;
    logic [31:0] readyState = 32'd60549;            // Separate stream for OutFabricReady
    logic        backPressure = 1'b0;
    int          checkCount;
    int          mismatchCount;
    int          unexpectedCount;

    tbClock #(.Period(8), .ResetCycles(2)) tbClock_i (.Clock(Clock), .rst(rst));

    tileMemWrap tileMemWrap_i (.TileId(OwnTile), .*);

    // ==============================
    // Helpers and reference
    // ==============================
    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = lcgNext(rngState);
        return rngState;
    endfunction

    // Slots spread over each array
    function automatic int iSlot(input int w);
        return w * 67;
    endfunction

    function automatic int dSlot(input int w);
        return w * 131;
    endfunction

    function automatic addrT slotAddr(input tileIdT t, input regionT rg, input int w);
        int slot;
        slot = (rg == IMemRegion) ? iSlot(w) : dSlot(w);
        return {t, rg, 20'(slot * 4)};
    endfunction

    // Store merged into the old word lane by lane
    function automatic wordT mergeBytes(input wordT old, input wordT data, input byteEnT be);
        wordT result;
        result = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = data[8*i +: 8];
            end
        end
        return result;
    endfunction

    // Response to one fabric read, zero data on a miss
    function automatic transVecT expectRsp(input addrT a, input tileIdT rid);
        wordT data;
        case (a[RegionMsb:RegionLsb])
            IMemRegion: data = iModel[a[11:2]];
            DMemRegion: data = dModel[a[12:2]];
            default:    data = '0;
        endcase
        return {rid, a[23:0], data, OpRdRsp, OwnTile};
    endfunction

    // Failures seen by the bound handshake checker
    function automatic int assertFailures();
        return tileMemWrap_i.tileMemAsserts_i.failCount;
    endfunction

    task automatic checkWord(input string what, input wordT expected, input wordT actual);
        checkCount++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t: %s expected %h got %h", $time, what, expected, actual);
        end
    endtask

    task automatic checkTrans(input string what, input transVecT expected, input transVecT actual);
        checkCount++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t: %s expected %h got %h", $time, what, expected, actual);
        end
    endtask

    task automatic reportCounts();
        $display("Checks %0d, mismatches %0d, unexpected outputs %0d, still expected %0d, %s %0d",
                 checkCount, mismatchCount, unexpectedCount, rspQ.size() + reqQ.size(),
                 "assertion failures", assertFailures());
    endtask

    // ==============================
    // Drivers
    // ==============================
    task automatic fabricSend(input addrT a, input wordT d, input opcodeT op, input tileIdT rid);
        @(negedge Clock);
        while (!InFabricReady) begin
            @(negedge Clock);
        end
        InFabricValid       = 1'b1;
        InFabricAddress     = a;
        InFabricData        = d;
        InFabricOpcode      = op;
        InFabricRequestorId = rid;
        @(negedge Clock);
        InFabricValid = 1'b0;
    endtask

    // Load word comes back one cycle later
    task automatic coreAccess(input addrT a, input wordT d, input byteEnT be, input logic wr,
                              output wordT rdData);
        @(negedge Clock);
        while (CoreStall) begin
            @(negedge Clock);
        end
        DMemAddressQ103H = a;
        DMemWrDataQ103H  = d;
        DMemByteEnQ103H  = be;
        DMemWrEnQ103H    = wr;
        DMemRdEnQ103H    = !wr;
        @(negedge Clock);
        rdData        = DMemRdRspQ104H;
        DMemWrEnQ103H = 1'b0;
        DMemRdEnQ103H = 1'b0;
    endtask

    task automatic fetchCheck(input int slot);
        @(negedge Clock);
        PcQ100H = 32'(slot * 4);
        @(negedge Clock);
        checkWord("instruction fetch", iModel[slot], InstructionQ101H);
    endtask

    task automatic waitDrain();
        while (rspQ.size() != 0 || reqQ.size() != 0) begin
            @(negedge Clock);
        end
        repeat (4) @(negedge Clock);                // Catch stray extra outputs
    endtask

    // ==============================
    // Output compare and fabric ready
    // ==============================
    always @(posedge Clock) begin
        transVecT seen;
        if (!rst && OutFabricValid && OutFabricReady) begin
            seen = {OutFabricAddress, OutFabricData, OutFabricOpcode, OutFabricRequestorId};
            if (OutFabricOpcode == OpRdRsp && rspQ.size() != 0) begin
                checkTrans("read response", rspQ.pop_front(), seen);
            end else if (OutFabricOpcode != OpRdRsp && reqQ.size() != 0) begin
                checkTrans("remote request", reqQ.pop_front(), seen);
            end else begin
                unexpectedCount++;
                $display("Fabric output %h at %0t was never expected", seen, $time);
            end
        end
    end

    initial begin
        OutFabricReady = 1'b1;
        forever begin
            @(negedge Clock);
            readyState     = lcgNext(readyState);
            OutFabricReady = !backPressure || readyState[31];   // Half the cycles when on
        end
    end

    // Watchdog
    initial begin
        repeat (NumOps * 40) @(posedge Clock);
        $display("Run did not finish within %0d cycles", NumOps * 40);
        reportCounts();
        $display("Simulation failed");
        $finish;
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        logic [31:0] r;
        wordT        rd;
        wordT        data;
        addrT        a;
        regionT      region;
        opcodeT      op;
        logic        pending;
        PcQ100H          = '0;
        DMemAddressQ103H = '0;
        DMemWrDataQ103H  = '0;
        DMemByteEnQ103H  = '0;
        DMemWrEnQ103H    = 1'b0;
        DMemRdEnQ103H    = 1'b0;
        InFabricValid    = 1'b0;
        InFabricAddress  = '0;
        InFabricData     = '0;
        InFabricOpcode   = OpRd;
        InFabricRequestorId = '0;
        wait (!rst);

        // Fabric writes to both regions, then core reads
        for (int w = 0; w < Words; w++) begin
            iModel[iSlot(w)] = nextRand();
            fabricSend(slotAddr(OwnTile, IMemRegion, w), iModel[iSlot(w)], OpWr, 8'h11);
            dModel[dSlot(w)] = nextRand();
            fabricSend(slotAddr(OwnTile, DMemRegion, w), dModel[dSlot(w)], OpWr, 8'h11);
        end
        for (int w = 0; w < Words; w++) begin
            fetchCheck(iSlot(w));
            coreAccess(slotAddr(LocalTileId, DMemRegion, w), '0, '0, 1'b0, rd);
            checkWord("core load", dModel[dSlot(w)], rd);
        end

        // Byte enable stores, both local aliases
        for (int n = 0; n < 24; n++) begin
            r    = nextRand();
            data = nextRand();
            dModel[dSlot(r[31:28])] = mergeBytes(dModel[dSlot(r[31:28])], data, r[27:24]);
            a = slotAddr(r[23] ? OwnTile : LocalTileId, DMemRegion, r[31:28]);
            coreAccess(a, data, r[27:24], 1'b1, rd);
        end
        for (int w = 0; w < Words; w++) begin
            coreAccess(slotAddr(OwnTile, DMemRegion, w), '0, '0, 1'b0, rd);
            checkWord("merged store", dModel[dSlot(w)], rd);
        end

        // Fabric reads including misses
        for (int n = 0; n < 24; n++) begin
            r      = nextRand();
            region = (r[31:30] == 2'd0) ? MissRegion : (r[29] ? IMemRegion : DMemRegion);
            a      = slotAddr(OwnTile, region, r[27:24]);
            rspQ.push_back(expectRsp(a, r[23:16]));
            fabricSend(a, '0, OpRd, r[23:16]);
        end
        waitDrain();

        // Remote core accesses leave local words alone
        for (int n = 0; n < Words; n++) begin
            r    = nextRand();
            data = nextRand();
            a    = slotAddr(tileIdT'(8'h40 + n), DMemRegion, n);
            reqQ.push_back({a, data, r[31] ? OpWr : OpRd, OwnTile});
            coreAccess(a, data, '1, r[31], rd);
            if (!r[31]) begin
                checkWord("remote load to core", '0, rd);
            end
        end
        for (int w = 0; w < Words; w++) begin
            coreAccess(slotAddr(LocalTileId, DMemRegion, w), '0, '0, 1'b0, rd);
            checkWord("local word after remote", dModel[dSlot(w)], rd);
        end
        waitDrain();

        // Both sources at once under fabric back-pressure
        backPressure = 1'b1;
        pending      = 1'b0;
        for (int n = 0; n < 80 || pending; n++) begin
            @(negedge Clock);
            r             = nextRand();
            InFabricValid = 1'b0;
            if (!pending) begin
                DMemWrEnQ103H = 1'b0;
                DMemRdEnQ103H = 1'b0;
            end
            if (n < 80 && r[31] && InFabricReady) begin
                a                   = slotAddr(OwnTile, r[30] ? IMemRegion : DMemRegion, r[27:24]);
                InFabricValid       = 1'b1;
                InFabricAddress     = a;
                InFabricOpcode      = OpRd;
                InFabricRequestorId = r[23:16];
                rspQ.push_back(expectRsp(a, r[23:16]));
            end
            if (n < 80 && !pending && r[15]) begin
                pending          = 1'b1;
                DMemAddressQ103H = slotAddr(tileIdT'(8'h40 + r[11:8]), DMemRegion, r[11:8]);
                DMemWrDataQ103H  = nextRand();
                DMemWrEnQ103H    = r[14];
                DMemRdEnQ103H    = !r[14];
            end
            // Stalled access stays on the port
            if (pending && !CoreStall) begin
                op = DMemWrEnQ103H ? OpWr : OpRd;
                reqQ.push_back({DMemAddressQ103H, DMemWrDataQ103H, op, OwnTile});
                pending = 1'b0;                     // Taken at the coming edge
            end
        end
        @(negedge Clock);
        InFabricValid = 1'b0;
        DMemWrEnQ103H = 1'b0;
        DMemRdEnQ103H = 1'b0;
        waitDrain();
        backPressure = 1'b0;

        reportCounts();
        if (mismatchCount == 0 && unexpectedCount == 0 && assertFailures() == 0
                && checkCount > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* testbench/tileMem_asserts.sv */
// Covers the outgoing fabric handshake and the core stall only, memory contents are not checked
module tileMem_asserts (
    input logic              Clock,
    input logic              rst,
    input logic              OutFabricValid,
    input logic              OutFabricReady,
    input tilePkg::transVecT OutFabricTrans,    // {address, data, opcode, requestor}
    input logic              CoreStall,
    input logic              InFabricReady,
    input tilePkg::fifoPtrT  ReqWrPtr           // Write pointer of reqFifo
);
    int failCount = 0;                          // Failed assertions so far

    // Quiet outputs right after a reset edge
    resetQuiet: assert property (@(posedge Clock)
        rst |=> (!OutFabricValid && !CoreStall && InFabricReady))
        else begin
            failCount++;
            $error("Fabric or core port active after a reset edge");
        end

    // Stalled transaction stays put
    holdStable: assert property (@(posedge Clock) disable iff (rst)
        (OutFabricValid && !OutFabricReady) |=> (OutFabricValid && $stable(OutFabricTrans)))
        else begin
            failCount++;
            $error("OutFabric changed while stalled by the fabric");
        end

    // Nothing enters the request queue across a stalled edge
    stallNoPush: assert property (@(posedge Clock) disable iff (rst)
        CoreStall |=> $stable(ReqWrPtr))
        else begin
            failCount++;
            $error("Request queue took an entry while CoreStall was high");
        end
endmodule

bind tileMemWrap tileMem_asserts tileMemAsserts_i (
    .Clock          (Clock),
    .rst            (rst),
    .OutFabricValid (OutFabricValid),
    .OutFabricReady (OutFabricReady),
    .OutFabricTrans ({OutFabricAddress, OutFabricData, OutFabricOpcode, OutFabricRequestorId}),
    .CoreStall      (CoreStall),
    .InFabricReady  (InFabricReady),
    .ReqWrPtr       (reqFifo.wrPtr)
);

/* testbench/tbClock.sv */
// Clock runs from time zero and reset is released on a falling edge after ResetCycles edges
module tbClock #(
    parameter int Period      = 8,
    parameter int ResetCycles = 2
) (
    output logic Clock,
    output logic rst
);
    initial begin
        Clock = 1'b0;
        forever #(Period / 2) Clock = ~Clock;
    end

    // Release away from the active edge
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;
    end
endmodule

/* rtl/tileMemWrap.sv */
// No control registers and the fabric arbitration id is not carried at this level
module tileMemWrap (
    input  logic              Clock,
    input  logic              rst,
    input  tilePkg::tileIdT   TileId,
    // Core instruction port
    input  tilePkg::addrT     PcQ100H,
    output tilePkg::wordT     InstructionQ101H,
    // Core data port
    input  tilePkg::addrT     DMemAddressQ103H,
    input  tilePkg::wordT     DMemWrDataQ103H,
    input  tilePkg::byteEnT   DMemByteEnQ103H,
    input  logic              DMemWrEnQ103H,
    input  logic              DMemRdEnQ103H,
    output tilePkg::wordT     DMemRdRspQ104H,
    output logic              CoreStall,
    // Fabric in
    input  logic              InFabricValid,
    output logic              InFabricReady,
    input  tilePkg::addrT     InFabricAddress,
    input  tilePkg::wordT     InFabricData,
    input  tilePkg::opcodeT   InFabricOpcode,
    input  tilePkg::tileIdT   InFabricRequestorId,
    // Fabric out
    output logic              OutFabricValid,
    input  logic              OutFabricReady,
    output tilePkg::addrT     OutFabricAddress,
    output tilePkg::wordT     OutFabricData,
    output tilePkg::opcodeT   OutFabricOpcode,
    output tilePkg::tileIdT   OutFabricRequestorId
);
    import tilePkg::*;

    fabricIf inFab ();
    fabricIf rspIf ();                              // Read responses into rspFifo
    fabricIf reqIf ();                              // Remote core requests into reqFifo
    fabricIf outFab ();

    logic     iMemFabWrEn;
    logic     dMemFabWrEn;
    logic     localWrEn;
    wordT     iMemFabRd;
    wordT     dMemFabRd;
    wordT     dMemCoreRd;
    logic     localRdQ104H;                         // Last core read was local
    transVecT rspPopVec;
    transVecT reqPopVec;
    transVecT winVec;
    logic     rspFull;
    logic     rspEmpty;
    logic     reqFull;
    logic     reqEmpty;
    fifoCntT  rspFree;
    logic [1:0] grant;                              // Bit 0 responses, bit 1 requests

    // ==============================
    // Boundary to interfaces
    // ==============================
    assign inFab.Valid       = InFabricValid;
    assign inFab.Address     = InFabricAddress;
    assign inFab.Data        = InFabricData;
    assign inFab.Opcode      = InFabricOpcode;
    assign inFab.RequestorId = InFabricRequestorId;
    assign InFabricReady     = inFab.Ready;

    // ==============================
    // Memories
    // ==============================
    dualPortMem #(.AdrsWidth(IMemAdrsMsb - 1)) iMem (
        .Clock    (Clock),
        .AddressA (PcQ100H[IMemAdrsMsb:2]),         // Fetch only
        .DataA    ('0),
        .WrEnA    (1'b0),
        .ByteEnA  ('0),
        .RdDataA  (InstructionQ101H),
        .AddressB (InFabricAddress[IMemAdrsMsb:2]),
        .DataB    (InFabricData),
        .WrEnB    (iMemFabWrEn),
        .ByteEnB  ('1),                             // Full word writes
        .RdDataB  (iMemFabRd)
    );

    dualPortMem #(.AdrsWidth(DMemAdrsMsb - 1)) dMem (
        .Clock    (Clock),
        .AddressA (DMemAddressQ103H[DMemAdrsMsb:2]),
        .DataA    (DMemWrDataQ103H),
        .WrEnA    (localWrEn),
        .ByteEnA  (DMemByteEnQ103H),
        .RdDataA  (dMemCoreRd),
        .AddressB (InFabricAddress[DMemAdrsMsb:2]),
        .DataB    (InFabricData),
        .WrEnB    (dMemFabWrEn),
        .ByteEnB  ('1),
        .RdDataB  (dMemFabRd)
    );

    // Remote loads return zero
    always_ff @(posedge Clock) begin
        if (rst) begin
            localRdQ104H <= 1'b0;
        end else begin
            localRdQ104H <= DMemRdEnQ103H && !reqIf.Valid;
        end
    end
    assign DMemRdRspQ104H = localRdQ104H ? dMemCoreRd : '0;

    // ==============================
    // Fabric and core request paths
    // ==============================
    fabricRspPath fabricRspPath_i (
        .Clock      (Clock),
        .rst        (rst),
        .TileId     (TileId),
        .InFabric   (inFab.sink),
        .IMemWrEn   (iMemFabWrEn),
        .DMemWrEn   (dMemFabWrEn),
        .IMemRdData (iMemFabRd),
        .DMemRdData (dMemFabRd),
        .RspOut     (rspIf.source),
        .FreeCount  (rspFree)
    );

    coreReqRouter coreReqRouter_i (
        .TileId           (TileId),
        .DMemAddressQ103H (DMemAddressQ103H),
        .DMemWrDataQ103H  (DMemWrDataQ103H),
        .DMemWrEnQ103H    (DMemWrEnQ103H),
        .DMemRdEnQ103H    (DMemRdEnQ103H),
        .Stall            (CoreStall),
        .LocalWrEn        (localWrEn),
        .ReqOut           (reqIf.source)
    );

    assign rspIf.Ready = !rspFull;
    assign reqIf.Ready = !reqFull;
    assign CoreStall   = reqFull;                   // Core holds its access

    // ==============================
    // Outgoing queues and arbitration
    // ==============================
    transFifo rspFifo (
        .Clock     (Clock),
        .rst       (rst),
        .Push      (rspIf.Valid && rspIf.Ready),
        .PushData  ({rspIf.Address, rspIf.Data, rspIf.Opcode, rspIf.RequestorId}),
        .Pop       (grant[0] && outFab.Ready),
        .PopData   (rspPopVec),
        .Full      (rspFull),
        .Empty     (rspEmpty),
        .FreeCount (rspFree)
    );

    transFifo reqFifo (
        .Clock     (Clock),
        .rst       (rst),
        .Push      (reqIf.Valid && reqIf.Ready),
        .PushData  ({reqIf.Address, reqIf.Data, reqIf.Opcode, reqIf.RequestorId}),
        .Pop       (grant[1] && outFab.Ready),
        .PopData   (reqPopVec),
        .Full      (reqFull),
        .Empty     (reqEmpty),
        .FreeCount ()                               // Only full matters here
    );

    fabricArbiter fabricArbiter_i (
        .Clock   (Clock),
        .rst     (rst),
        .Request ({!reqEmpty, !rspEmpty}),
        .Ready   (outFab.Ready),
        .Grant   (grant)
    );

    // Winner onto the fabric
    assign winVec       = grant[0] ? rspPopVec : reqPopVec;
    assign outFab.Valid = |grant;
    assign outFab.Ready = OutFabricReady;
    assign {outFab.Address, outFab.Data, outFab.Opcode, outFab.RequestorId} = winVec;

    assign OutFabricValid       = outFab.Valid;
    assign OutFabricAddress     = outFab.Address;
    assign OutFabricData        = outFab.Data;
    assign OutFabricOpcode      = outFab.Opcode;
    assign OutFabricRequestorId = outFab.RequestorId;

endmodule

/* rtl/coreReqRouter.sv */
// Remote loads are only forwarded and the core never gets their data back
module coreReqRouter (
    input  tilePkg::tileIdT TileId,
    input  tilePkg::addrT   DMemAddressQ103H,
    input  tilePkg::wordT   DMemWrDataQ103H,
    input  logic            DMemWrEnQ103H,
    input  logic            DMemRdEnQ103H,
    input  logic            Stall,
    output logic            LocalWrEn,
    fabricIf.source         ReqOut
);
    import tilePkg::*;

    tileIdT target;
    logic   isLocal;
    logic   access;

    // ==============================
    // Locality check
    // ==============================
    assign target  = DMemAddressQ103H[TileIdMsb:TileIdLsb];
    assign isLocal = (target == LocalTileId) || (target == TileId);
    assign access  = DMemWrEnQ103H || DMemRdEnQ103H;

    // Held stores write once the stall clears
    assign LocalWrEn = DMemWrEnQ103H && isLocal && !Stall;

    // Remote request toward the request FIFO
    assign ReqOut.Valid       = access && !isLocal;
    assign ReqOut.Address     = DMemAddressQ103H;
    assign ReqOut.Data        = DMemWrDataQ103H;
    assign ReqOut.Opcode      = DMemWrEnQ103H ? OpWr : OpRd; // Store wins if both set
    assign ReqOut.RequestorId = TileId;

endmodule

/* rtl/fabricRspPath.sv */
// Fabric writes are full word, a region miss reads zero and is dropped on write
module fabricRspPath (
    input  logic             Clock,
    input  logic             rst,
    input  tilePkg::tileIdT  TileId,
    fabricIf.sink            InFabric,
    output logic             IMemWrEn,
    output logic             DMemWrEn,
    input  tilePkg::wordT    IMemRdData,
    input  tilePkg::wordT    DMemRdData,
    fabricIf.source          RspOut,
    input  tilePkg::fifoCntT FreeCount
);
    import tilePkg::*;

    regionT region;
    logic   iHit;
    logic   dHit;
    logic   accept;                                 // Handshake this cycle
    logic   rdAccept;
    logic   wrAccept;
    logic   rdValidQ;                               // Read waiting on memory data
    logic   iHitQ;
    logic   dHitQ;
    addrT   rspAddrQ;
    tileIdT rspIdQ;

    // ==============================
    // Request decode
    // ==============================
    assign region   = InFabric.Address[RegionMsb:RegionLsb];
    assign iHit     = (region == IMemRegion);
    assign dHit     = (region == DMemRegion);
    assign accept   = InFabric.Valid && InFabric.Ready;
    assign rdAccept = accept && (InFabric.Opcode == OpRd);
    assign wrAccept = accept && (InFabric.Opcode == OpWr);

    // Writes land at the request edge
    assign IMemWrEn = wrAccept && iHit;
    assign DMemWrEn = wrAccept && dHit;

    // Keep one free slot per read that has not reached the FIFO
    assign InFabric.Ready = (FreeCount > fifoCntT'(rdValidQ));

    // ==============================
    // Response stage
    // ==============================
    always_ff @(posedge Clock) begin
        if (rst) begin
            rdValidQ <= 1'b0;
            iHitQ    <= 1'b0;
            dHitQ    <= 1'b0;
        end else begin
            rdValidQ <= rdAccept;
            iHitQ    <= rdAccept && iHit;
            dHitQ    <= rdAccept && dHit;
        end
    end

    // Payload, meaningful only with rdValidQ
    always_ff @(posedge Clock) begin
        rspAddrQ <= {InFabric.RequestorId, InFabric.Address[RegionMsb:0]}; // Back to requestor
        rspIdQ   <= TileId;
    end

    // Memory data arrives the same cycle as the registered flags
    assign RspOut.Valid       = rdValidQ;
    assign RspOut.Address     = rspAddrQ;
    assign RspOut.Opcode      = OpRdRsp;
    assign RspOut.RequestorId = rspIdQ;
    assign RspOut.Data        = iHitQ ? IMemRdData :
                                dHitQ ? DMemRdData :
                                        '0;         // Region miss

endmodule

/* rtl/fabricArbiter.sv */
// Two-client round robin that keeps a stalled grant until the fabric takes it
module fabricArbiter (
    input  logic       Clock,
    input  logic       rst,
    input  logic [1:0] Request,
    input  logic       Ready,
    output logic [1:0] Grant
);
    logic       lastWinner;                         // Client served most recently
    logic       holdQ;                              // Grant blocked by fabric last cycle
    logic [1:0] holdGrantQ;
    logic [1:0] rrGrant;

    // Other client first, then last winner
    always_comb begin
        rrGrant = 2'b00;
        if (Request[~lastWinner]) begin
            rrGrant[~lastWinner] = 1'b1;
        end else if (Request[lastWinner]) begin
            rrGrant[lastWinner] = 1'b1;
        end
    end

    assign Grant = holdQ ? holdGrantQ : rrGrant;    // Keeps OutFabric stable under stall

    always_ff @(posedge Clock) begin
        if (rst) begin
            lastWinner <= 1'b1;                     // Client 0 first after reset
            holdQ      <= 1'b0;
        end else begin
            holdQ <= (|Grant) && !Ready;
            if ((|Grant) && Ready) begin
                lastWinner <= Grant[1];             // Move only on a real transfer
            end
        end
    end

    // Qualified by holdQ
    always_ff @(posedge Clock) begin
        holdGrantQ <= Grant;
    end

endmodule

/* rtl/transFifo.sv */
// Show-ahead FIFO where a push when full or a pop when empty is dropped without notice
module transFifo (
    input  logic              Clock,
    input  logic              rst,
    input  logic              Push,
    input  tilePkg::transVecT PushData,
    input  logic              Pop,
    output tilePkg::transVecT PopData,
    output logic              Full,
    output logic              Empty,
    output tilePkg::fifoCntT  FreeCount
);
    import tilePkg::*;

    transVecT entries [FifoDepth];
    fifoPtrT  wrPtr;
    fifoPtrT  rdPtr;
    fifoCntT  count;                                // Occupied entries
    logic     doPush;
    logic     doPop;

    // Pointer advance with wrap
    function automatic fifoPtrT nextPtr(input fifoPtrT ptr);
        return (ptr == fifoPtrT'(FifoDepth - 1)) ? '0 : fifoPtrT'(ptr + 1'b1);
    endfunction

    assign Full      = (count == fifoCntT'(FifoDepth));
    assign Empty     = (count == '0);
    assign FreeCount = fifoCntT'(FifoDepth) - count;
    assign doPush    = Push && !Full;               // Overflow ignored
    assign doPop     = Pop && !Empty;               // Underflow ignored
    assign PopData   = entries[rdPtr];              // Head visible before pop

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge Clock) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Idle or push and pop together
            endcase
        end
    end

    // Storage
    always_ff @(posedge Clock) begin
        if (doPush) begin
            entries[wrPtr] <= PushData;
        end
    end

endmodule

/* rtl/dualPortMem.sv */
// Behavioral memory with no reset and if both ports write one word in a cycle port B wins
module dualPortMem #(
    parameter int AdrsWidth = 10        // Word address bits
) (
    input  logic                 Clock,
    // Port A
    input  logic [AdrsWidth-1:0] AddressA,
    input  tilePkg::wordT        DataA,
    input  logic                 WrEnA,
    input  tilePkg::byteEnT      ByteEnA,
    output tilePkg::wordT        RdDataA,
    // Port B
    input  logic [AdrsWidth-1:0] AddressB,
    input  tilePkg::wordT        DataB,
    input  logic                 WrEnB,
    input  tilePkg::byteEnT      ByteEnB,
    output tilePkg::wordT        RdDataB
);
    import tilePkg::*;

    localparam int Words = 2 ** AdrsWidth;

    wordT mem [Words];

    // ==============================
    // Read before write, both ports
    // ==============================
    always_ff @(posedge Clock) begin
        RdDataA <= mem[AddressA];                   // Old word on collision
        RdDataB <= mem[AddressB];
        for (int i = 0; i < ByteEnWidth; i++) begin
            if (WrEnA && ByteEnA[i]) begin
                mem[AddressA][8*i +: 8] <= DataA[8*i +: 8];
            end
            // Later assignment, so B overrides A
            if (WrEnB && ByteEnB[i]) begin
                mem[AddressB][8*i +: 8] <= DataB[8*i +: 8];
            end
        end
    end

endmodule

/* rtl/fabricIf.sv */
// One fabric transaction with valid/ready and the move happens only when both are high
interface fabricIf;
    import tilePkg::*;

    logic   Valid;
    logic   Ready;                  // Back-pressure from the sink
    addrT   Address;
    wordT   Data;
    opcodeT Opcode;
    tileIdT RequestorId;            // Tile that issued the request

    // Producer side
    modport source (
        output Valid,
        output Address,
        output Data,
        output Opcode,
        output RequestorId,
        input  Ready
    );

    // Consumer side
    modport sink (
        input  Valid,
        input  Address,
        input  Data,
        input  Opcode,
        input  RequestorId,
        output Ready
    );

endinterface

/* rtl/tilePkg.sv */
// Tile id 0 always aliases the local tile and both transaction FIFOs share one fixed depth
package tilePkg;

    // ==============================
    // Widths
    // ==============================
    localparam int WordWidth   = 32;
    localparam int AddrWidth   = 32;
    localparam int TileIdWidth = 8;
    localparam int ByteEnWidth = 4;                 // One enable per byte lane
    localparam int OpcodeWidth = 2;
    localparam int TransWidth  = AddrWidth + WordWidth + OpcodeWidth + TileIdWidth; // 74

    // ==============================
    // Address map
    // ==============================
    localparam int TileIdMsb   = 31;                // Target tile field
    localparam int TileIdLsb   = 24;
    localparam int RegionMsb   = 23;                // Memory region field
    localparam int RegionLsb   = 20;
    localparam int IMemAdrsMsb = 11;                // 1K words of instruction memory
    localparam int DMemAdrsMsb = 12;                // 2K words of data memory

    // Transaction FIFO depth
    localparam int FifoDepth = 4;

    // ==============================
    // Vector types
    // ==============================
    typedef logic [WordWidth-1:0]              wordT;
    typedef logic [AddrWidth-1:0]              addrT;
    typedef logic [TileIdWidth-1:0]            tileIdT;
    typedef logic [ByteEnWidth-1:0]            byteEnT;
    typedef logic [OpcodeWidth-1:0]            opcodeT;
    typedef logic [TransWidth-1:0]             transVecT; // {address, data, opcode, requestor}
    typedef logic [RegionMsb-RegionLsb:0]      regionT;
    typedef logic [$clog2(FifoDepth)-1:0]      fifoPtrT;
    typedef logic [$clog2(FifoDepth+1)-1:0]    fifoCntT;  // Holds 0..FifoDepth

    // Opcodes
    localparam opcodeT OpRd    = 2'd0;
    localparam opcodeT OpWr    = 2'd1;
    localparam opcodeT OpRdRsp = 2'd2;

    // Region codes
    localparam regionT IMemRegion = 4'd1;
    localparam regionT DMemRegion = 4'd2;

    localparam tileIdT LocalTileId = 8'd0;          // Alias for own tile

endpackage
